// ==== logic/cpu_cfg_pkg.sv ====
package cpu_cfg_pkg;

  // datapath and instruction width
  localparam int word_width = 32;

  typedef logic [word_width-1:0] word_t;

  // code memory holds sixteen words and is indexed by pc[5:2]
  localparam int code_words = 16;
  localparam int code_addr_width = $clog2(code_words);

  typedef logic [code_addr_width-1:0] code_addr_t;

  // r0 to r14 are stored, r15 is the pc
  localparam int reg_count = 15;

  // program image, one hex word per line
  localparam string program_file = "tb/program.hex";

endpackage

// ==== logic/cpu_isa_pkg.sv ====
package cpu_isa_pkg;

  typedef logic [31:0] inst_t;
  typedef logic [3:0]  reg_idx_t;
  typedef logic [3:0]  cond_t;
  typedef logic [3:0]  opcode_t;
  typedef logic [1:0]  inst_kind_t;
  // n, z, c, v from the top bit down
  typedef logic [3:0]  flags_t;

  localparam reg_idx_t reg_lr = 4'd14;
  localparam reg_idx_t reg_pc = 4'd15;

  // 4'b1111 is left out and never passes
  localparam cond_t cond_eq = 4'b0000;
  localparam cond_t cond_ne = 4'b0001;
  localparam cond_t cond_cs = 4'b0010;
  localparam cond_t cond_cc = 4'b0011;
  localparam cond_t cond_mi = 4'b0100;
  localparam cond_t cond_pl = 4'b0101;
  localparam cond_t cond_vs = 4'b0110;
  localparam cond_t cond_vc = 4'b0111;
  localparam cond_t cond_hi = 4'b1000;
  localparam cond_t cond_ls = 4'b1001;
  localparam cond_t cond_ge = 4'b1010;
  localparam cond_t cond_lt = 4'b1011;
  localparam cond_t cond_gt = 4'b1100;
  localparam cond_t cond_le = 4'b1101;
  localparam cond_t cond_al = 4'b1110;

  localparam opcode_t opcode_and = 4'b0000;
  localparam opcode_t opcode_eor = 4'b0001;
  localparam opcode_t opcode_sub = 4'b0010;
  localparam opcode_t opcode_rsb = 4'b0011;
  localparam opcode_t opcode_add = 4'b0100;
  localparam opcode_t opcode_adc = 4'b0101;
  localparam opcode_t opcode_sbc = 4'b0110;
  localparam opcode_t opcode_rsc = 4'b0111;
  localparam opcode_t opcode_tst = 4'b1000;
  localparam opcode_t opcode_teq = 4'b1001;
  localparam opcode_t opcode_cmp = 4'b1010;
  localparam opcode_t opcode_cmn = 4'b1011;
  localparam opcode_t opcode_orr = 4'b1100;
  localparam opcode_t opcode_mov = 4'b1101;
  localparam opcode_t opcode_bic = 4'b1110;
  localparam opcode_t opcode_mvn = 4'b1111;

  localparam inst_kind_t kind_data_proc = 2'b00;
  localparam inst_kind_t kind_branch    = 2'b10;

  localparam int flag_n = 3;
  localparam int flag_z = 2;
  localparam int flag_c = 1;
  localparam int flag_v = 0;

  // instruction field positions
  localparam int cond_msb    = 31;
  localparam int cond_lsb    = 28;
  localparam int kind_msb    = 27;
  localparam int kind_lsb    = 26;
  localparam int imm_sel_bit = 25;
  localparam int opcode_msb  = 24;
  localparam int opcode_lsb  = 21;
  localparam int s_bit       = 20;
  // link shares bit 24 with the opcode field, branches only
  localparam int link_bit    = 24;
  localparam int rn_msb      = 19;
  localparam int rn_lsb      = 16;
  localparam int rd_msb      = 15;
  localparam int rd_lsb      = 12;
  localparam int imm_msb     = 7;
  localparam int imm_lsb     = 0;
  localparam int rm_msb      = 3;
  localparam int rm_lsb      = 0;
  localparam int offset_msb  = 23;
  localparam int offset_lsb  = 0;

endpackage

// ==== logic/fetch_unit.sv ====
`timescale 1ns/1ns

module fetch_unit (
  input  logic               clk,
  input  logic               nreset,
  input  logic               take_branch,
  output cpu_cfg_pkg::word_t pc,
  output cpu_isa_pkg::inst_t inst
);
  import cpu_cfg_pkg::*;
  import cpu_isa_pkg::*;

  inst_t      code_mem [code_words];
  code_addr_t code_addr;
  word_t      branch_offset;
  word_t      branch_target;

  // rom image, filled at elaboration
  initial begin
    $readmemh(program_file, code_mem);
  end

  // word index, byte offset bits dropped
  assign code_addr = pc[code_addr_width+1:2];
  assign inst      = code_mem[code_addr];

  // signed word offset, relative to pc+8
  assign branch_offset = word_t'(signed'(inst[offset_msb:offset_lsb])) << 2;
  assign branch_target = pc + 32'd8 + branch_offset;

  always_ff @(posedge clk) begin
    if (!nreset) begin
      pc <= '0;
    end else if (take_branch) begin
      pc <= branch_target;
    end else begin
      pc <= pc + 32'd4;
    end
  end

  // branch targets and sequential steps keep the pc on a word boundary
  pc_aligned: assert property (@(posedge clk) nreset |=> (pc[1:0] == 2'b00));

endmodule

// ==== logic/instr_decoder.sv ====
`timescale 1ns/1ns

module instr_decoder (
  input  cpu_isa_pkg::inst_t    inst,
  input  cpu_isa_pkg::flags_t   flags,
  input  cpu_cfg_pkg::word_t    rd2,
  output cpu_isa_pkg::reg_idx_t rs1,
  output cpu_isa_pkg::reg_idx_t rs2,
  output cpu_isa_pkg::reg_idx_t wr_idx,
  output cpu_cfg_pkg::word_t    operand2,
  output cpu_isa_pkg::opcode_t  opcode,
  output logic                  set_flags,
  output logic                  is_link,
  output logic                  exec,
  output logic                  wr_en,
  output logic                  take_branch
);
  import cpu_cfg_pkg::*;
  import cpu_isa_pkg::*;

  cond_t      cond;
  inst_kind_t kind;
  reg_idx_t   rd;
  logic       cond_pass;
  logic       is_branch;
  logic       is_compare;
  logic       wants_write;

  assign cond   = inst[cond_msb:cond_lsb];
  assign kind   = inst[kind_msb:kind_lsb];
  assign rd     = inst[rd_msb:rd_lsb];
  assign opcode = inst[opcode_msb:opcode_lsb];
  assign rs1    = inst[rn_msb:rn_lsb];
  assign rs2    = inst[rm_msb:rm_lsb];

  always_comb begin
    case (cond)
      cond_eq: cond_pass = flags[flag_z];
      cond_ne: cond_pass = !flags[flag_z];
      cond_cs: cond_pass = flags[flag_c];
      cond_cc: cond_pass = !flags[flag_c];
      cond_mi: cond_pass = flags[flag_n];
      cond_pl: cond_pass = !flags[flag_n];
      cond_vs: cond_pass = flags[flag_v];
      cond_vc: cond_pass = !flags[flag_v];
      cond_hi: cond_pass = flags[flag_c] && !flags[flag_z];
      cond_ls: cond_pass = !flags[flag_c] || flags[flag_z];
      cond_ge: cond_pass = (flags[flag_n] == flags[flag_v]);
      cond_lt: cond_pass = (flags[flag_n] != flags[flag_v]);
      cond_gt: cond_pass = !flags[flag_z] && (flags[flag_n] == flags[flag_v]);
      cond_le: cond_pass = flags[flag_z] || (flags[flag_n] != flags[flag_v]);
      cond_al: cond_pass = 1'b1;
      default: cond_pass = 1'b0;
    endcase
  end

  assign is_branch   = (kind == kind_branch);
  assign exec        = (kind == kind_data_proc) && cond_pass;
  assign take_branch = is_branch && cond_pass;
  assign is_link     = is_branch && inst[link_bit];

  // these only touch the flags
  assign is_compare = opcode inside {opcode_tst, opcode_teq, opcode_cmp, opcode_cmn};

  assign wr_idx      = is_link ? reg_lr : rd;
  assign wants_write = (exec && !is_compare) || (take_branch && is_link);
  // pc writes are dropped here, nowhere else
  assign wr_en       = wants_write && (wr_idx != reg_pc);
  assign set_flags   = exec && inst[s_bit] && (rd != reg_pc);

  // zero-extended 8-bit immediate or unshifted rm
  assign operand2 = inst[imm_sel_bit] ? word_t'(inst[imm_msb:imm_lsb]) : rd2;

  no_pc_write: assert final (!(wr_en && (wr_idx == reg_pc)));

endmodule

// ==== logic/reg_file.sv ====
`timescale 1ns/1ns

module reg_file (
  input  logic                  clk,
  input  logic                  nreset,
  input  logic                  wr_en,
  input  cpu_isa_pkg::reg_idx_t rs1,
  input  cpu_isa_pkg::reg_idx_t rs2,
  input  cpu_isa_pkg::reg_idx_t wr_idx,
  input  cpu_cfg_pkg::word_t    wr_data,
  input  cpu_cfg_pkg::word_t    pc,
  output cpu_cfg_pkg::word_t    rd1,
  output cpu_cfg_pkg::word_t    rd2,
  output cpu_cfg_pkg::word_t    r2_value
);
  import cpu_cfg_pkg::*;
  import cpu_isa_pkg::*;

  word_t regs [reg_count];

  always_ff @(posedge clk) begin
    if (!nreset) begin
      for (int i = 0; i < reg_count; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en) begin
      regs[wr_idx] <= wr_data;
    end
  end

  // r15 has no storage and reads back as the pc
  assign rd1 = (rs1 == reg_pc) ? pc : regs[rs1];
  assign rd2 = (rs2 == reg_pc) ? pc : regs[rs2];

  // debug tap on r2
  assign r2_value = regs[2];

endmodule

// ==== logic/alu_flags.sv ====
`timescale 1ns/1ns

module alu_flags (
  input  logic                 clk,
  input  logic                 nreset,
  input  logic                 set_flags,
  input  logic                 is_link,
  input  cpu_isa_pkg::opcode_t opcode,
  input  cpu_cfg_pkg::word_t   a,
  input  cpu_cfg_pkg::word_t   b,
  input  cpu_cfg_pkg::word_t   pc,
  output cpu_cfg_pkg::word_t   result,
  output cpu_isa_pkg::flags_t  flags
);
  import cpu_cfg_pkg::*;
  import cpu_isa_pkg::*;

  word_t               add_x;
  word_t               add_y;
  logic                add_cin;
  logic                arith;
  logic [word_width:0] sum;
  logic [word_width:0] alu_out;
  logic                overflow;

  // subtraction feeds the inverted operand with a carry in
  always_comb begin
    add_x   = a;
    add_y   = b;
    add_cin = 1'b0;
    arith   = 1'b1;
    case (opcode)
      opcode_add, opcode_cmn: begin
        add_cin = 1'b0;
      end
      opcode_adc: begin
        add_cin = flags[flag_c];
      end
      opcode_sub, opcode_cmp: begin
        add_y   = ~b;
        add_cin = 1'b1;
      end
      opcode_sbc: begin
        add_y   = ~b;
        add_cin = flags[flag_c];
      end
      opcode_rsb: begin
        add_x   = b;
        add_y   = ~a;
        add_cin = 1'b1;
      end
      opcode_rsc: begin
        add_x   = b;
        add_y   = ~a;
        add_cin = flags[flag_c];
      end
      default: arith = 1'b0;
    endcase
  end

  assign sum = {1'b0, add_x} + {1'b0, add_y} + {{word_width{1'b0}}, add_cin};

  // operands agree in sign but the sum does not
  assign overflow = (add_x[word_width-1] == add_y[word_width-1]) &&
                    (sum[word_width-1] != add_x[word_width-1]);

  // logical results carry a zero in the top bit
  always_comb begin
    case (opcode)
      opcode_and, opcode_tst: alu_out = {1'b0, a & b};
      opcode_eor, opcode_teq: alu_out = {1'b0, a ^ b};
      opcode_orr:             alu_out = {1'b0, a | b};
      opcode_mov:             alu_out = {1'b0, b};
      opcode_bic:             alu_out = {1'b0, a & ~b};
      opcode_mvn:             alu_out = {1'b0, ~b};
      default:                alu_out = sum;
    endcase
  end

  // branch-with-link returns the address after the branch
  assign result = is_link ? pc + 32'd4 : alu_out[word_width-1:0];

  always_ff @(posedge clk) begin
    if (!nreset) begin
      flags <= '0;
    end else if (set_flags) begin
      flags[flag_n] <= alu_out[word_width-1];
      flags[flag_z] <= (alu_out[word_width-1:0] == '0);
      flags[flag_c] <= alu_out[word_width];
      // v holds its value across logical ops
      if (arith) begin
        flags[flag_v] <= overflow;
      end
    end
  end

  flags_hold: assert property (@(posedge clk) disable iff (!nreset)
    !set_flags |=> $stable(flags));

endmodule

// ==== logic/cpu_top.sv ====
`timescale 1ns/1ns

module cpu_top (
  input  logic       clk,
  input  logic       nreset,
  output logic       led,
  output logic [7:0] debug_port1,
  output logic [7:0] debug_port2,
  output logic [7:0] debug_port3
);
  import cpu_cfg_pkg::*;
  import cpu_isa_pkg::*;

  word_t    pc;
  inst_t    inst;
  flags_t   flags;
  reg_idx_t rs1;
  reg_idx_t rs2;
  reg_idx_t wr_idx;
  word_t    rd1;
  word_t    rd2;
  word_t    r2_value;
  word_t    operand2;
  word_t    result;
  opcode_t  opcode;
  logic     set_flags;
  logic     is_link;
  logic     wr_en;
  logic     take_branch;

  fetch_unit i_fetch (
    .clk         (clk),
    .nreset      (nreset),
    .take_branch (take_branch),
    .pc          (pc),
    .inst        (inst)
  );

  instr_decoder i_decoder (
    .inst        (inst),
    .flags       (flags),
    .rd2         (rd2),
    .rs1         (rs1),
    .rs2         (rs2),
    .wr_idx      (wr_idx),
    .operand2    (operand2),
    .opcode      (opcode),
    .set_flags   (set_flags),
    .is_link     (is_link),
    .exec        (),
    .wr_en       (wr_en),
    .take_branch (take_branch)
  );

  reg_file i_regs (
    .clk      (clk),
    .nreset   (nreset),
    .wr_en    (wr_en),
    .rs1      (rs1),
    .rs2      (rs2),
    .wr_idx   (wr_idx),
    .wr_data  (result),
    .pc       (pc),
    .rd1      (rd1),
    .rd2      (rd2),
    .r2_value (r2_value)
  );

  alu_flags i_alu (
    .clk       (clk),
    .nreset    (nreset),
    .set_flags (set_flags),
    .is_link   (is_link),
    .opcode    (opcode),
    .a         (rd1),
    .b         (operand2),
    .pc        (pc),
    .result    (result),
    .flags     (flags)
  );

  // led blinks with the low word bit of the pc
  assign led         = pc[2];
  assign debug_port1 = pc[9:2];
  assign debug_port2 = inst[7:0];
  assign debug_port3 = r2_value[7:0];

endmodule

// ==== include/tb_ref_model.svh ====
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

import cpu_cfg_pkg::*;
import cpu_isa_pkg::*;

// return address and branch base, relative to the model pc
localparam int m_link_offset = 4;
localparam int m_pipe_offset = 8;

inst_t  m_code [code_words];
word_t  m_pc;
word_t  m_regs [reg_count];
flags_t m_flags;

// clears the model state and reloads the program
function automatic void model_reset();
  $readmemh(program_file, m_code);
  m_pc = '0;
  m_flags = '0;
  foreach (m_regs[i]) begin
    m_regs[i] = '0;
  end
endfunction

function automatic inst_t model_inst();
  return m_code[m_pc[code_addr_width+1:2]];
endfunction

function automatic word_t model_read(reg_idx_t idx);
  return (idx == reg_pc) ? m_pc : m_regs[idx];
endfunction

// cond[3:1] picks the test, cond[0] inverts it
function automatic logic model_cond(cond_t cond);
  logic base;
  case (cond[3:1])
    3'd0: base = m_flags[flag_z];
    3'd1: base = m_flags[flag_c];
    3'd2: base = m_flags[flag_n];
    3'd3: base = m_flags[flag_v];
    3'd4: base = m_flags[flag_c] && !m_flags[flag_z];
    3'd5: base = (m_flags[flag_n] == m_flags[flag_v]);
    3'd6: base = !m_flags[flag_z] && (m_flags[flag_n] == m_flags[flag_v]);
    default: base = 1'b1;
  endcase
  return base ^ cond[0];
endfunction

// executes the instruction at the model pc
function automatic void model_step();
  inst_t               i;
  opcode_t             op;
  reg_idx_t            rd;
  word_t               a;
  word_t               b;
  word_t               x;
  word_t               y;
  logic                cin;
  logic                arith;
  logic [word_width:0] sum;
  i = model_inst();
  op = i[opcode_msb:opcode_lsb];
  rd = i[rd_msb:rd_lsb];
  if (!model_cond(i[cond_msb:cond_lsb])) begin
    m_pc = m_pc + 4;
  end else if (i[kind_msb:kind_lsb] == kind_branch) begin
    if (i[link_bit]) begin
      m_regs[reg_lr] = m_pc + m_link_offset;
    end
    m_pc = m_pc + m_pipe_offset + {{6{i[offset_msb]}}, i[offset_msb:offset_lsb], 2'b00};
  end else if (i[kind_msb:kind_lsb] == kind_data_proc) begin
    a = model_read(i[rn_msb:rn_lsb]);
    b = i[imm_sel_bit] ? word_t'(i[imm_msb:imm_lsb]) : model_read(i[rm_msb:rm_lsb]);
    x = (op inside {opcode_rsb, opcode_rsc}) ? b : a;
    y = (op inside {opcode_sub, opcode_cmp, opcode_sbc}) ? ~b : b;
    if (op inside {opcode_rsb, opcode_rsc}) begin
      y = ~a;
    end
    cin = (op inside {opcode_sub, opcode_cmp, opcode_rsb});
    if (op inside {opcode_adc, opcode_sbc, opcode_rsc}) begin
      cin = m_flags[flag_c];
    end
    sum = {1'b0, x} + {1'b0, y} + {{word_width{1'b0}}, cin};
    arith = 1'b0;
    case (op)
      opcode_and, opcode_tst: sum = {1'b0, a & b};
      opcode_eor, opcode_teq: sum = {1'b0, a ^ b};
      opcode_orr: sum = {1'b0, a | b};
      opcode_mov: sum = {1'b0, b};
      opcode_bic: sum = {1'b0, a & ~b};
      opcode_mvn: sum = {1'b0, ~b};
      default: arith = 1'b1;
    endcase
    if (!(op inside {opcode_tst, opcode_teq, opcode_cmp, opcode_cmn}) && rd != reg_pc) begin
      m_regs[rd] = sum[word_width-1:0];
    end
    if (i[s_bit] && rd != reg_pc) begin
      m_flags[flag_n] = sum[word_width-1];
      m_flags[flag_z] = (sum[word_width-1:0] == '0);
      m_flags[flag_c] = sum[word_width];
      if (arith) begin
        m_flags[flag_v] = (x[31] == y[31]) && (sum[31] != x[31]);
      end
    end
    m_pc = m_pc + 4;
  end else begin
    m_pc = m_pc + 4;
  end
endfunction

`endif

// ==== tb/tb_cpu.sv ====
`timescale 1ns/1ns

module tb_cpu;

  `include "tb_ref_model.svh"

  // byte addresses of the interesting spots in program.hex
  localparam word_t bne_addr   = 32'h10;
  localparam word_t bcs_addr   = 32'h1c;
  localparam word_t bcs_target = 32'h24;
  localparam word_t bl_addr    = 32'h24;
  localparam word_t loop_addr  = 32'h30;

  localparam int run_length  = 60;
  localparam int run_timeout = 200;

  logic       clk;
  logic       nreset;
  logic       led;
  logic [7:0] debug_port1;
  logic [7:0] debug_port2;
  logic [7:0] debug_port3;

  logic       exp_led;
  logic [7:0] exp_port1;
  logic [7:0] exp_port2;
  logic [7:0] exp_port3;

  int steps;
  int cycles;
  int carry_hits;
  int zero_hits;
  int link_hits;

  cpu_top i_dut (
    .clk         (clk),
    .nreset      (nreset),
    .led         (led),
    .debug_port1 (debug_port1),
    .debug_port2 (debug_port2),
    .debug_port3 (debug_port3)
  );

  task automatic stop_with_failure();
    $display("Checks failed");
    $fatal(1, "simulation stopped on error");
  endtask

  task automatic report_mismatch(string name, logic [31:0] got, logic [31:0] expected);
    $display("ERR %s got 0x%h expected 0x%h", name, got, expected);
    stop_with_failure();
  endtask

  // expected port values from the model state before each edge
  assign exp_led   = m_pc[2];
  assign exp_port1 = m_pc[9:2];
  assign exp_port2 = m_code[m_pc[code_addr_width+1:2]][7:0];
  assign exp_port3 = m_regs[2][7:0];

  initial begin
    clk = 1'b0;
    forever begin
      #5 clk = ~clk;
    end
  end

  // one model instruction per rising edge once reset is released
  always @(posedge clk) begin
    if (nreset) begin
      if (m_pc == bcs_addr) begin
        carry_hits++;
      end
      if (m_pc == bne_addr && m_regs[2] == 32'd5) begin
        zero_hits++;
      end
      if (m_pc == loop_addr) begin
        link_hits++;
      end
      model_step();
      steps++;
    end
  end

  reset_outputs: assert property (@(posedge clk) $rose(nreset) |->
    (led == 1'b0 && debug_port1 == 8'h00 && debug_port3 == 8'h00))
    else report_mismatch("led/debug_port1/debug_port3",
      {15'h0, $sampled(led), $sampled(debug_port1), $sampled(debug_port3)}, 32'h0);

  pc_track: assert property (@(posedge clk) disable iff (!nreset)
    debug_port1 == exp_port1)
    else report_mismatch("debug_port1", $sampled(debug_port1), $sampled(exp_port1));

  inst_track: assert property (@(posedge clk) disable iff (!nreset)
    debug_port2 == exp_port2)
    else report_mismatch("debug_port2", $sampled(debug_port2), $sampled(exp_port2));

  led_track: assert property (@(posedge clk) disable iff (!nreset)
    led == exp_led)
    else report_mismatch("led", $sampled(led), $sampled(exp_led));

  r2_track: assert property (@(posedge clk) disable iff (!nreset)
    debug_port3 == exp_port3)
    else report_mismatch("debug_port3", $sampled(debug_port3), $sampled(exp_port3));

  // the ADDS before it leaves C set, so BCS skips one word
  carry_branch: assert property (@(posedge clk) disable iff (!nreset)
    (exp_port1 == 8'(bcs_addr >> 2)) |=> (debug_port1 == 8'(bcs_target >> 2)))
    else report_mismatch("debug_port1", $sampled(debug_port1), bcs_target >> 2);

  // CMP r2, #5 sets Z, so BNE falls through
  zero_exit: assert property (@(posedge clk) disable iff (!nreset)
    (exp_port1 == 8'(bne_addr >> 2) && exp_port3 == 8'h05)
    |=> (debug_port1 == 8'((bne_addr + 4) >> 2)))
    else report_mismatch("debug_port1", $sampled(debug_port1), (bne_addr + 4) >> 2);

  // r2 holds the BL return address while the final loop spins
  link_write: assert property (@(posedge clk) disable iff (!nreset)
    (exp_port1 == 8'(loop_addr >> 2)) |-> (debug_port3 == 8'(bl_addr + 4)))
    else report_mismatch("debug_port3", $sampled(debug_port3), bl_addr + 4);

  initial begin
    nreset     = 1'b0;
    steps      = 0;
    cycles     = 0;
    carry_hits = 0;
    zero_hits  = 0;
    link_hits  = 0;
    model_reset();
    repeat (2) @(negedge clk);
    nreset = 1'b1;

    while (steps < run_length && cycles < run_timeout) begin
      @(negedge clk);
      cycles++;
    end

    if (steps < run_length) begin
      $display("timeout: only %0d of %0d instructions ran", steps, run_length);
      stop_with_failure();
    end else if (carry_hits == 0 || zero_hits == 0 || link_hits == 0) begin
      $display("program never reached the carry, zero or link check");
      stop_with_failure();
    end else begin
      $display("All checks passed");
      $finish;
    end
  end

endmodule

// ==== cpu.f ====
+incdir+include
logic/cpu_cfg_pkg.sv
logic/cpu_isa_pkg.sv
logic/fetch_unit.sv
logic/instr_decoder.sv
logic/reg_file.sv
logic/alu_flags.sv
logic/cpu_top.sv
tb/tb_cpu.sv

// ==== tb/program.hex ====
// one 32-bit instruction word per line, from address 0x00 upward
E3B01001
E3A02000
E0822001
E3520005
1AFFFFFC
E3E02004
E29220FF
2A000000
E3A02077
EB000000
E3A02055
E1A0200E
EAFFFFFE
00000000
00000000
00000000
